/* src/prf_pkg.sv */
package prf_pkg;

    // ------------------------------------------------------------
    // sizes
    // ------------------------------------------------------------

    // physical registers
    localparam int PR_COUNT = 64;
    localparam int LOG_PR_COUNT = $clog2(PR_COUNT);

    // banks, selected by the low bits of the register number
    localparam int BANK_COUNT = 4;
    localparam int LOG_BANK_COUNT = $clog2(BANK_COUNT);
    localparam int BANK_DEPTH = PR_COUNT / BANK_COUNT;

    // rob
    localparam int ROB_ENTRIES = 64;
    localparam int LOG_ROB_ENTRIES = $clog2(ROB_ENTRIES);

    // default requester counts, top level passes these down
    localparam int DEF_RR_COUNT = 4;
    localparam int DEF_WR_COUNT = 4;

    // ------------------------------------------------------------
    // types
    // ------------------------------------------------------------

    typedef logic [31:0] word_t;
    // low bits = bank, high bits = row in bank
    typedef logic [LOG_PR_COUNT-1:0] pr_t;
    typedef logic [LOG_PR_COUNT-LOG_BANK_COUNT-1:0] upper_pr_t;
    typedef logic [LOG_ROB_ENTRIES-1:0] rob_index_t;

    // ------------------------------------------------------------
    // arbitration helpers, generic over requester count
    // ------------------------------------------------------------

    virtual class pick_c #(parameter int WIDTH = 4);

        // one-hot of highest set bit
        static function logic [WIDTH-1:0] priority_pick(input logic [WIDTH-1:0] req);
            logic [WIDTH-1:0] pick;
            pick = '0;
            // walk up so the top bit has the last say
            for (int i = 0; i < WIDTH; i++) begin
                if (req[i]) begin
                    pick = '0;
                    pick[i] = 1'b1;
                end
            end
            return pick;
        endfunction

        // below-boundary requests first, else highest overall
        static function logic [WIDTH-1:0] fair_pick(
            input logic [WIDTH-1:0] req,
            input logic [WIDTH-1:0] mask
        );
            if (|(req & mask)) begin
                return priority_pick(req & mask);
            end
            return priority_pick(req);
        endfunction

    endclass

endpackage

/* src/prf_wb_if.sv */
`timescale 1ns/1ps

interface prf_wb_if;
    import prf_pkg::*;

    // one-cycle write strobe for this bank
    logic       valid;
    word_t      data;
    // row inside the bank
    upper_pr_t  upper_pr;
    // rob entry woken by this writeback
    rob_index_t rob_index;

    // arbiter drives all of it from registers
    modport arbiter (
        output valid,
        output data,
        output upper_pr,
        output rob_index
    );

    // ram only needs the write fields
    modport ram (
        input valid,
        input data,
        input upper_pr
    );

endinterface

/* src/prf_bank_ram.sv */
`timescale 1ns/1ps

module prf_bank_ram (
    input  logic                CLK,
    input  logic                nRST,
    // registered row indices from the read arbiter
    input  prf_pkg::upper_pr_t  rd_index0,
    input  prf_pkg::upper_pr_t  rd_index1,
    output prf_pkg::word_t      rd_data0,
    output prf_pkg::word_t      rd_data1,
    // write side, one strobe per cycle at most
    prf_wb_if.ram               wr
);
    import prf_pkg::*;

    // ------------------------------------------------------------
    // storage
    // ------------------------------------------------------------

    word_t mem [BANK_DEPTH];

    // write at the end of the bus cycle
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            // registers come up as zero
            for (int i = 0; i < BANK_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (wr.valid) begin
            mem[wr.upper_pr] <= wr.data;
        end
    end

    // ------------------------------------------------------------
    // read ports
    // ------------------------------------------------------------

    // combinational from the already registered index
    assign rd_data0 = mem[rd_index0];
    assign rd_data1 = mem[rd_index1];

    // ------------------------------------------------------------
    // checks
    // ------------------------------------------------------------

    // row from the arbiter bus register must be clean on a write
    a_wr_row_known: assert property (
        @(posedge CLK) disable iff (!nRST)
        wr.valid |-> !$isunknown(wr.upper_pr)
    );

endmodule

/* src/prf_wb_arbiter.sv */
`timescale 1ns/1ps

module prf_wb_arbiter #(
    parameter int WR_COUNT = prf_pkg::DEF_WR_COUNT
) (
    input  logic                                CLK,
    input  logic                                nRST,
    // writeback requests
    input  logic [WR_COUNT-1:0]                 wb_valid,
    input  prf_pkg::word_t [WR_COUNT-1:0]       wb_data,
    input  prf_pkg::pr_t [WR_COUNT-1:0]         wb_pr,
    input  prf_pkg::rob_index_t [WR_COUNT-1:0]  wb_rob_index,
    output logic [WR_COUNT-1:0]                 wb_ready,
    // per-bank write bus
    prf_wb_if.arbiter                           bus [prf_pkg::BANK_COUNT]
);
    import prf_pkg::*;

    // held losers, one deep per requester
    logic [WR_COUNT-1:0]        held_valid;
    word_t [WR_COUNT-1:0]       held_data;
    pr_t [WR_COUNT-1:0]         held_pr;
    rob_index_t [WR_COUNT-1:0]  held_rob;

    // held entry or new one, held wins
    logic [WR_COUNT-1:0]        merged_valid;
    word_t [WR_COUNT-1:0]       merged_data;
    pr_t [WR_COUNT-1:0]         merged_pr;
    rob_index_t [WR_COUNT-1:0]  merged_rob;

    logic [BANK_COUNT-1:0][WR_COUNT-1:0]    req_by_bank;
    logic [BANK_COUNT-1:0][WR_COUNT-1:0]    grant_by_bank;
    logic [WR_COUNT-1:0]                    grant_any;

    // fairness mask, bits below last highest grant
    logic [WR_COUNT-1:0]        mask;
    logic [WR_COUNT-1:0]        next_mask;

    // bus register inputs
    logic [BANK_COUNT-1:0]      next_bus_valid;
    word_t [BANK_COUNT-1:0]     next_bus_data;
    upper_pr_t [BANK_COUNT-1:0] next_bus_row;
    rob_index_t [BANK_COUNT-1:0] next_bus_rob;

    // ------------------------------------------------------------
    // ready
    // ------------------------------------------------------------

    // stall only with a held entry and a new one at once
    assign wb_ready = ~(wb_valid & held_valid);

    // ------------------------------------------------------------
    // merge, demux and pick
    // ------------------------------------------------------------

    always_comb begin
        req_by_bank = '0;
        for (int w = 0; w < WR_COUNT; w++) begin
            merged_valid[w] = held_valid[w] | wb_valid[w];
            merged_data[w] = held_valid[w] ? held_data[w] : wb_data[w];
            merged_pr[w] = held_valid[w] ? held_pr[w] : wb_pr[w];
            merged_rob[w] = held_valid[w] ? held_rob[w] : wb_rob_index[w];
            // route by low bits of the register
            req_by_bank[merged_pr[w][LOG_BANK_COUNT-1:0]][w] = merged_valid[w];
        end

        grant_any = '0;
        for (int b = 0; b < BANK_COUNT; b++) begin
            grant_by_bank[b] = pick_c#(WR_COUNT)::fair_pick(req_by_bank[b], mask);
            grant_any |= grant_by_bank[b];

            // one-hot mux of the winner
            next_bus_valid[b] = |req_by_bank[b];
            next_bus_data[b] = '0;
            next_bus_row[b] = '0;
            next_bus_rob[b] = '0;
            for (int w = 0; w < WR_COUNT; w++) begin
                if (grant_by_bank[b][w]) begin
                    next_bus_data[b] |= merged_data[w];
                    next_bus_row[b] |= merged_pr[w][LOG_PR_COUNT-1:LOG_BANK_COUNT];
                    next_bus_rob[b] |= merged_rob[w];
                end
            end
        end

        // boundary moves to the highest grant, all banks together
        next_mask = '0;
        for (int w = WR_COUNT - 2; w >= 0; w--) begin
            next_mask[w] = next_mask[w+1] | grant_any[w+1];
        end
    end

    // ------------------------------------------------------------
    // state
    // ------------------------------------------------------------

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            held_valid <= '0;
            mask <= '0;
        end else begin
            held_valid <= merged_valid & ~grant_any;
            mask <= next_mask;
        end
    end

    // payload just follows the merge, stable while held
    always_ff @(posedge CLK) begin
        held_data <= merged_data;
        held_pr <= merged_pr;
        held_rob <= merged_rob;
    end

    // bus registers, one set per bank
    for (genvar b = 0; b < BANK_COUNT; b++) begin : g_bus
        always_ff @(posedge CLK or negedge nRST) begin
            if (!nRST) begin
                bus[b].valid <= 1'b0;
            end else begin
                bus[b].valid <= next_bus_valid[b];
            end
        end

        always_ff @(posedge CLK) begin
            bus[b].data <= next_bus_data[b];
            bus[b].upper_pr <= next_bus_row[b];
            bus[b].rob_index <= next_bus_rob[b];
        end

        // at most one winner per bank
        a_grant_onehot: assert property (
            @(posedge CLK) disable iff (!nRST)
            $onehot0(grant_by_bank[b])
        );
    end

    // a loser keeps its entry untouched until it wins
    for (genvar w = 0; w < WR_COUNT; w++) begin : g_held_chk
        a_held_persists: assert property (
            @(posedge CLK) disable iff (!nRST)
            held_valid[w] && !grant_any[w] |=>
                held_valid[w] && $stable(held_pr[w]) && $stable(held_data[w])
        );
    end

endmodule

/* src/prf_read_arbiter.sv */
`timescale 1ns/1ps

module prf_read_arbiter #(
    parameter int RR_COUNT = prf_pkg::DEF_RR_COUNT
) (
    input  logic                                        CLK,
    input  logic                                        nRST,
    // single-cycle read strobes
    input  logic [RR_COUNT-1:0]                         req_valid,
    input  prf_pkg::pr_t [RR_COUNT-1:0]                 req_pr,
    // ack pulses in the grant cycle and port names the bank port
    output logic [RR_COUNT-1:0]                         ack,
    output logic [RR_COUNT-1:0]                         port,
    // registered row per bank and port
    output prf_pkg::upper_pr_t [prf_pkg::BANK_COUNT-1:0] rd_index0,
    output prf_pkg::upper_pr_t [prf_pkg::BANK_COUNT-1:0] rd_index1
);
    import prf_pkg::*;

    // unacked requests
    logic [RR_COUNT-1:0]    held_valid;
    pr_t [RR_COUNT-1:0]     held_pr;

    // held request wins over a new strobe
    logic [RR_COUNT-1:0]    merged_valid;
    pr_t [RR_COUNT-1:0]     merged_pr;

    logic [BANK_COUNT-1:0][RR_COUNT-1:0]    req_by_bank;
    logic [BANK_COUNT-1:0][RR_COUNT-1:0]    grant0_by_bank;
    logic [BANK_COUNT-1:0][RR_COUNT-1:0]    grant1_by_bank;
    logic [RR_COUNT-1:0]                    grant0_any;
    logic [RR_COUNT-1:0]                    grant1_any;

    // fairness mask
    logic [RR_COUNT-1:0]    mask;
    logic [RR_COUNT-1:0]    next_mask;

    upper_pr_t [BANK_COUNT-1:0] next_index0;
    upper_pr_t [BANK_COUNT-1:0] next_index1;

    // ------------------------------------------------------------
    // merge, demux and two-port pick
    // ------------------------------------------------------------

    always_comb begin
        req_by_bank = '0;
        for (int r = 0; r < RR_COUNT; r++) begin
            merged_valid[r] = held_valid[r] | req_valid[r];
            merged_pr[r] = held_valid[r] ? held_pr[r] : req_pr[r];
            req_by_bank[merged_pr[r][LOG_BANK_COUNT-1:0]][r] = merged_valid[r];
        end

        grant0_any = '0;
        grant1_any = '0;
        for (int b = 0; b < BANK_COUNT; b++) begin
            // port 0 picks first and port 1 picks from the rest
            grant0_by_bank[b] = pick_c#(RR_COUNT)::fair_pick(req_by_bank[b], mask);
            grant1_by_bank[b] = pick_c#(RR_COUNT)::fair_pick(
                req_by_bank[b] & ~grant0_by_bank[b], mask);
            grant0_any |= grant0_by_bank[b];
            grant1_any |= grant1_by_bank[b];

            // row of each winner
            next_index0[b] = '0;
            next_index1[b] = '0;
            for (int r = 0; r < RR_COUNT; r++) begin
                if (grant0_by_bank[b][r]) begin
                    next_index0[b] |= merged_pr[r][LOG_PR_COUNT-1:LOG_BANK_COUNT];
                end
                if (grant1_by_bank[b][r]) begin
                    next_index1[b] |= merged_pr[r][LOG_PR_COUNT-1:LOG_BANK_COUNT];
                end
            end
        end

        // mask below the highest grant of this cycle on either port
        next_mask = '0;
        for (int r = RR_COUNT - 2; r >= 0; r--) begin
            next_mask[r] = next_mask[r+1] | grant0_any[r+1] | grant1_any[r+1];
        end
    end

    assign ack = grant0_any | grant1_any;
    assign port = grant1_any;

    // ------------------------------------------------------------
    // state
    // ------------------------------------------------------------

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            held_valid <= '0;
            mask <= '0;
            rd_index0 <= '0;
            rd_index1 <= '0;
        end else begin
            held_valid <= merged_valid & ~ack;
            mask <= next_mask;
            // data shows up one cycle after the ack
            rd_index0 <= next_index0;
            rd_index1 <= next_index1;
        end
    end

    // register number of each unacked request
    always_ff @(posedge CLK) begin
        held_pr <= merged_pr;
    end

    // ------------------------------------------------------------
    // checks
    // ------------------------------------------------------------

    // a requester never owns both ports of any bank
    a_ports_disjoint: assert property (
        @(posedge CLK) disable iff (!nRST)
        (grant0_any & grant1_any) == '0
    );

endmodule

/* src/prf.sv */
`timescale 1ns/1ps

module prf #(
    parameter int RR_COUNT = prf_pkg::DEF_RR_COUNT,
    parameter int WR_COUNT = prf_pkg::DEF_WR_COUNT
) (
    input  logic                                                CLK,
    input  logic                                                nRST,

    // read requests
    input  logic [RR_COUNT-1:0]                                 reg_read_req_valid,
    input  prf_pkg::pr_t [RR_COUNT-1:0]                         reg_read_req_pr,
    output logic [RR_COUNT-1:0]                                 reg_read_ack,
    output logic [RR_COUNT-1:0]                                 reg_read_port,

    // read data, by bank then port
    output prf_pkg::word_t [prf_pkg::BANK_COUNT-1:0][1:0]       reg_read_data,

    // writeback requests
    input  logic [WR_COUNT-1:0]                                 wb_valid,
    input  prf_pkg::word_t [WR_COUNT-1:0]                       wb_data,
    input  prf_pkg::pr_t [WR_COUNT-1:0]                         wb_pr,
    input  prf_pkg::rob_index_t [WR_COUNT-1:0]                  wb_rob_index,
    output logic [WR_COUNT-1:0]                                 wb_ready,

    // writeback bus, by bank
    output logic [prf_pkg::BANK_COUNT-1:0]                      wb_bus_valid,
    output prf_pkg::word_t [prf_pkg::BANK_COUNT-1:0]            wb_bus_data,
    output prf_pkg::upper_pr_t [prf_pkg::BANK_COUNT-1:0]        wb_bus_upper_pr,
    output prf_pkg::rob_index_t [prf_pkg::BANK_COUNT-1:0]       wb_bus_rob_index
);
    import prf_pkg::*;

    // registered rows from the read arbiter
    upper_pr_t [BANK_COUNT-1:0] rd_index0;
    upper_pr_t [BANK_COUNT-1:0] rd_index1;

    // one write bus per bank
    prf_wb_if wb_if [BANK_COUNT] ();

    // ------------------------------------------------------------
    // arbiters
    // ------------------------------------------------------------

    prf_read_arbiter #(
        .RR_COUNT(RR_COUNT)
    ) u_read_arb (
        .CLK(CLK),
        .nRST(nRST),
        .req_valid(reg_read_req_valid),
        .req_pr(reg_read_req_pr),
        .ack(reg_read_ack),
        .port(reg_read_port),
        .rd_index0(rd_index0),
        .rd_index1(rd_index1)
    );

    prf_wb_arbiter #(
        .WR_COUNT(WR_COUNT)
    ) u_wb_arb (
        .CLK(CLK),
        .nRST(nRST),
        .wb_valid(wb_valid),
        .wb_data(wb_data),
        .wb_pr(wb_pr),
        .wb_rob_index(wb_rob_index),
        .wb_ready(wb_ready),
        .bus(wb_if)
    );

    // ------------------------------------------------------------
    // banks
    // ------------------------------------------------------------

    for (genvar b = 0; b < BANK_COUNT; b++) begin : g_bank
        prf_bank_ram u_ram (
            .CLK(CLK),
            .nRST(nRST),
            .rd_index0(rd_index0[b]),
            .rd_index1(rd_index1[b]),
            .rd_data0(reg_read_data[b][0]),
            .rd_data1(reg_read_data[b][1]),
            .wr(wb_if[b])
        );

        // bus goes out as seen by the ram
        assign wb_bus_valid[b] = wb_if[b].valid;
        assign wb_bus_data[b] = wb_if[b].data;
        assign wb_bus_upper_pr[b] = wb_if[b].upper_pr;
        assign wb_bus_rob_index[b] = wb_if[b].rob_index;
    end

endmodule

/* tests/tb_prf.sv */
`timescale 1ns/1ps

module tb_prf;
    import prf_pkg::*;

    // one table row holds a write group or a read group
    typedef struct packed {
        logic [2:0]         test;
        logic               is_write;
        logic [3:0]         who;
        pr_t [3:0]          pr;
        word_t [3:0]        data;
        rob_index_t [3:0]   rob;
        logic               chk_first;
        // expected winners of the first cycle as one-hot per requester
        logic [3:0]         first_ack;
        logic [3:0]         first_port;
    } op_t;

    logic                           CLK;
    logic                           nRST;
    logic [3:0]                     reg_read_req_valid;
    pr_t [3:0]                      reg_read_req_pr;
    logic [3:0]                     reg_read_ack;
    logic [3:0]                     reg_read_port;
    word_t [BANK_COUNT-1:0][1:0]    reg_read_data;
    logic [3:0]                     wb_valid;
    word_t [3:0]                    wb_data;
    pr_t [3:0]                      wb_pr;
    rob_index_t [3:0]               wb_rob_index;
    logic [3:0]                     wb_ready;
    logic [BANK_COUNT-1:0]          wb_bus_valid;
    word_t [BANK_COUNT-1:0]         wb_bus_data;
    upper_pr_t [BANK_COUNT-1:0]     wb_bus_upper_pr;
    rob_index_t [BANK_COUNT-1:0]    wb_bus_rob_index;

    // reference register contents updated on each bus pulse
    word_t      model [PR_COUNT];
    op_t        ops [$];
    integer     seed;
    int         errors = 0;
    int         test_errors = 0;
    int         tests_passed = 0;
    int         tests_failed = 0;
    int         cycles = 0;
    int         cycle_limit = 0;
    logic [2:0] cur_test;

    prf #(
        .RR_COUNT(DEF_RR_COUNT),
        .WR_COUNT(DEF_WR_COUNT)
    ) u_dut (
        .CLK(CLK),
        .nRST(nRST),
        .reg_read_req_valid(reg_read_req_valid),
        .reg_read_req_pr(reg_read_req_pr),
        .reg_read_ack(reg_read_ack),
        .reg_read_port(reg_read_port),
        .reg_read_data(reg_read_data),
        .wb_valid(wb_valid),
        .wb_data(wb_data),
        .wb_pr(wb_pr),
        .wb_rob_index(wb_rob_index),
        .wb_ready(wb_ready),
        .wb_bus_valid(wb_bus_valid),
        .wb_bus_data(wb_bus_data),
        .wb_bus_upper_pr(wb_bus_upper_pr),
        .wb_bus_rob_index(wb_bus_rob_index)
    );

    // ------------------------------------------------------------
    // clock and cycle limit
    // ------------------------------------------------------------

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    initial begin
        forever begin
            @(posedge CLK);
            cycles++;
        end
    end

    initial begin
        wait (cycle_limit != 0 && cycles >= cycle_limit);
        $display("timeout: run did not finish within %0d cycles", cycle_limit);
        $display("=== FAIL ===");
        $finish;
    end

    // ------------------------------------------------------------
    // checks and reporting
    // ------------------------------------------------------------

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic report_error(input string what);
        $display("error: %s", what);
        errors++;
        test_errors++;
    endtask

    function automatic string test_name(input logic [2:0] t);
        case (t)
            3'd1: return "after reset";
            3'd2: return "write then read, every bank";
            3'd3: return "writeback conflict";
            3'd4: return "read conflict";
            default: return "random traffic";
        endcase
    endfunction

    task automatic close_test(input logic [2:0] t);
        if (test_errors == 0) begin
            tests_passed++;
            $display("test %0d (%s): passed", t, test_name(t));
        end else begin
            tests_failed++;
            $display("test %0d (%s): failed, %0d errors", t, test_name(t), test_errors);
        end
        test_errors = 0;
    endtask

    // ------------------------------------------------------------
    // stimulus table
    // ------------------------------------------------------------

    // 16 rows with one register of each bank per row
    task automatic add_sweep(input logic [2:0] t);
        op_t op;
        for (int r = 0; r < BANK_DEPTH; r++) begin
            op = '0;
            op.test = t;
            op.who = 4'hf;
            for (int w = 0; w < 4; w++) begin
                op.pr[w] = pr_t'(4 * r + w);
            end
            ops.push_back(op);
        end
    endtask

    task automatic build_table();
        op_t         op;
        logic [31:0] rnd;
        int          k;
        add_sweep(3'd1);
        // one write per register with the requester rotating every four
        for (int i = 0; i < PR_COUNT; i++) begin
            op = '0;
            op.test = 3'd2;
            op.is_write = 1'b1;
            k = (i / 4) % 4;
            op.who[k] = 1'b1;
            op.pr[k] = pr_t'(i);
            op.data[k] = 32'h5a00_0000 ^ (32'(i) * 32'h0001_0203);
            op.rob[k] = rob_index_t'(i);
            ops.push_back(op);
        end
        add_sweep(3'd2);
        // all four into bank 2 and the highest index wins first
        op = '0;
        op.test = 3'd3;
        op.is_write = 1'b1;
        op.who = 4'hf;
        op.chk_first = 1'b1;
        op.first_ack = 4'b1000;
        for (int w = 0; w < 4; w++) begin
            op.pr[w] = pr_t'(4 * w + 2);
            op.data[w] = 32'hc0f1_0000 + 32'(w);
            op.rob[w] = rob_index_t'(40 + w);
        end
        ops.push_back(op);
        // three readers on bank 1 where 2 gets port 0 and 1 gets port 1
        op = '0;
        op.test = 3'd4;
        op.who = 4'b0111;
        op.chk_first = 1'b1;
        op.first_ack = 4'b0110;
        op.first_port = 4'b0010;
        for (int w = 0; w < 3; w++) begin
            op.pr[w] = pr_t'(4 * w + 1);
        end
        ops.push_back(op);
        // random writes with each row read back by the next one
        for (int n = 0; n < 8; n++) begin
            op = '0;
            op.test = 3'd5;
            op.is_write = 1'b1;
            op.who = 4'hf;
            for (int w = 0; w < 4; w++) begin
                rnd = $random(seed);
                op.pr[w] = rnd[5:0];
                rnd = $random(seed);
                op.data[w] = rnd;
                op.rob[w] = rob_index_t'(4 * n + w);
            end
            ops.push_back(op);
            op.is_write = 1'b0;
            ops.push_back(op);
        end
    endtask

    // ------------------------------------------------------------
    // row execution
    // ------------------------------------------------------------

    task automatic run_write(input op_t op);
        logic [3:0] pending;
        logic [3:0] seen;
        logic [3:0] onehot;
        logic       first;
        int         hit;
        int         n;
        pending = op.who;
        seen = '0;
        first = 1'b1;
        n = 0;
        while (seen != op.who && n < 8) begin
            @(posedge CLK);
            wb_valid <= pending;
            wb_data <= op.data;
            wb_pr <= op.pr;
            wb_rob_index <= op.rob;
            @(negedge CLK);
            // taken when valid meets ready
            pending &= ~(wb_valid & wb_ready);
            for (int b = 0; b < BANK_COUNT; b++) begin
                if (wb_bus_valid[b]) begin
                    hit = -1;
                    for (int w = 0; w < 4; w++) begin
                        if (op.who[w] && op.pr[w][1:0] == b[1:0]
                                && op.rob[w] == wb_bus_rob_index[b]) begin
                            hit = w;
                        end
                    end
                    if (hit < 0) begin
                        report_error($sformatf("unexpected writeback on bank %0d bus", b));
                    end else begin
                        if (seen[hit]) begin
                            report_error($sformatf("writeback of requester %0d seen twice", hit));
                        end
                        seen[hit] = 1'b1;
                        check("wb_bus_data", wb_bus_data[b], op.data[hit]);
                        check("wb_bus_upper_pr", 32'(wb_bus_upper_pr[b]), 32'(op.pr[hit][5:2]));
                        if (op.chk_first && first) begin
                            onehot = '0;
                            onehot[hit] = 1'b1;
                            check("first writeback winner", 32'(onehot), 32'(op.first_ack));
                        end
                        first = 1'b0;
                        // ram takes it at the end of this cycle
                        model[{wb_bus_upper_pr[b], b[1:0]}] = op.data[hit];
                    end
                end
            end
            n++;
        end
        if (seen != op.who) begin
            report_error("writeback did not reach the bus within 8 cycles");
        end
        @(posedge CLK);
        wb_valid <= '0;
        // every entry is out so no bus may pulse again
        @(negedge CLK);
        check("wb_bus_valid", 32'(wb_bus_valid), 32'h0);
    endtask

    task automatic run_read(input op_t op);
        logic [3:0]  pending;
        logic [3:0]  due;
        logic [3:0]  due_port;
        word_t [3:0] due_exp;
        int          n;
        pending = op.who;
        due = '0;
        due_port = '0;
        due_exp = '0;
        n = 0;
        // one-cycle strobe
        @(posedge CLK);
        reg_read_req_valid <= op.who;
        reg_read_req_pr <= op.pr;
        while ((pending != '0 || due != '0) && n < 8) begin
            @(negedge CLK);
            // data for the previous cycle's acks
            for (int w = 0; w < 4; w++) begin
                if (due[w]) begin
                    check($sformatf("reg_read_data[%0d][%0d]", op.pr[w][1:0], due_port[w]),
                        reg_read_data[op.pr[w][1:0]][due_port[w]], due_exp[w]);
                end
            end
            due = '0;
            check("wb_bus_valid", 32'(wb_bus_valid), 32'h0);
            if (n == 0 && op.chk_first) begin
                check("reg_read_ack", 32'(reg_read_ack & op.who), 32'(op.first_ack));
                check("reg_read_port", 32'(reg_read_port & op.first_ack), 32'(op.first_port));
            end
            if ((reg_read_ack & ~pending) != '0) begin
                report_error("ack for a requester with no open read");
            end
            for (int w = 0; w < 4; w++) begin
                if (reg_read_ack[w] && pending[w]) begin
                    due[w] = 1'b1;
                    due_port[w] = reg_read_port[w];
                    due_exp[w] = model[op.pr[w]];
                end
            end
            pending &= ~reg_read_ack;
            n++;
            @(posedge CLK);
            reg_read_req_valid <= '0;
        end
        if (pending != '0 || due != '0) begin
            report_error("read not acked and answered within 8 cycles");
        end
    endtask

    // ------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------

    initial begin
        nRST = 1'b0;
        reg_read_req_valid = '0;
        reg_read_req_pr = '0;
        wb_valid = '0;
        wb_data = '0;
        wb_pr = '0;
        wb_rob_index = '0;
        seed = 32'h35c2460d;
        foreach (model[i]) begin
            model[i] = '0;
        end
        build_table();
        cycle_limit = 20 * ops.size() + 200;
        repeat (8) @(posedge CLK);
        nRST <= 1'b1;
        @(negedge CLK);
        // idle outputs out of reset
        cur_test = 3'd1;
        check("wb_bus_valid", 32'(wb_bus_valid), 32'h0);
        check("wb_ready", 32'(wb_ready), 32'hf);
        check("reg_read_ack", 32'(reg_read_ack), 32'h0);
        foreach (ops[i]) begin
            if (ops[i].test != cur_test) begin
                close_test(cur_test);
                cur_test = ops[i].test;
            end
            if (ops[i].is_write) begin
                run_write(ops[i]);
            end else begin
                run_read(ops[i]);
            end
            // quiet gap lets the masks fall back to zero
            repeat (2) @(posedge CLK);
        end
        close_test(cur_test);
        $display("tests passed %0d, tests failed %0d, errors %0d",
            tests_passed, tests_failed, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* filelist.f */
src/prf_pkg.sv
src/prf_wb_if.sv
src/prf_bank_ram.sv
src/prf_wb_arbiter.sv
src/prf_read_arbiter.sv
src/prf.sv
tests/tb_prf.sv

/* Makefile */
# Verilator build and run of the register file testbench

TOP := tb_prf
LOG := sim.log

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "=== PASS ===" $(LOG); then echo "simulation ended early"; exit 1; fi
	@echo "simulation passed"

obj_dir/V$(TOP): filelist.f $(wildcard src/*.sv tests/*.sv)
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP)

lint:
	verilator --lint-only --timing --assert -f filelist.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)
